// ==== lanzonesCore.f ====
rtl/isaPkg.sv
rtl/corePkg.sv
rtl/busSequencer.sv
rtl/instrDecode.sv
rtl/execUnit.sv
rtl/regFile.sv
rtl/writeBack.sv
rtl/lanzonesCore.sv
sim/lanzonesTb.sv

// ==== rtl/busSequencer.sv ====
module busSequencer (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     loadEn,
   input  logic                     busAck,
   input  logic [isaPkg::xlen-1:0]  busRData,
   input  logic                     isStore,
   input  logic                     isLoad,
   input  logic                     isHalt,
   input  logic                     invalid,
   input  logic [isaPkg::xlen-1:0]  aluOut,
   input  logic [isaPkg::xlen-1:0]  rs2Data,
   output logic                     busReq,
   output logic [isaPkg::xlen-1:0]  busAddr,
   output logic                     busWe,
   output logic [isaPkg::xlen-1:0]  busWData,
   output logic [isaPkg::xlen-1:0]  instr,
   output corePkg::state_e          state,
   output logic                     halt
);

   logic [isaPkg::xlen-1:0] pc;
   logic                    startFetch;
   logic                    startMem;
   logic                    done;

   assign done = busReq && busAck;

   // after a store ack the fetch state raises the request itself
   assign startFetch = (state == corePkg::halted && loadEn) ||
                       (state == corePkg::writeRes) ||
                       (state == corePkg::fetch && !busReq);
   assign startMem   = state == corePkg::execute && (isLoad || isStore) && !isHalt && !invalid;

   assign halt = (state == corePkg::halted);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= corePkg::halted;
         pc     <= '0;
         busReq <= 1'b0;
         busWe  <= 1'b0;
      end else begin
         if (startFetch || startMem) begin
            busReq <= 1'b1;
         end else if (done) begin
            busReq <= 1'b0;
         end
         if (startMem) begin
            busWe <= isStore;
         end else if (done) begin
            busWe <= 1'b0;
         end
         case (state)
            corePkg::halted: if (loadEn) state <= corePkg::fetch;
            corePkg::fetch: begin
               if (done) begin
                  pc    <= pc + 1;   // word addressed
                  state <= corePkg::execute;
               end
            end
            corePkg::execute: begin
               if (isHalt || invalid) begin
                  state <= corePkg::halted;
               end else if (startMem) begin
                  state <= corePkg::memAccess;
               end else begin
                  state <= corePkg::writeRes;
               end
            end
            corePkg::memAccess: begin
               if (done) begin
                  if (isLoad) begin
                     state <= corePkg::writeRes;
                  end else begin
                     state <= corePkg::fetch;   // sw has nothing to write back
                  end
               end
            end
            corePkg::writeRes: state <= corePkg::fetch;
            default: state <= corePkg::halted;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (startFetch) begin
         busAddr <= pc;
      end else if (startMem) begin
         busAddr  <= aluOut;
         busWData <= rs2Data;
      end
      if (state == corePkg::fetch && done) begin
         instr <= busRData;
      end
   end

   // request held with unchanged payload until acknowledged
   assert property (@(posedge clk) disable iff (!rstn)
      busReq && !busAck |=> busReq && $stable(busAddr) && $stable(busWe) && $stable(busWData))
      else $error("bus request changed before acknowledge");

   assert property (@(posedge clk) disable iff (!rstn) done |=> !busReq)
      else $error("bus request still high after acknowledge");

endmodule

// ==== rtl/corePkg.sv ====
package corePkg;

   // one instruction in flight, no overlap
   typedef enum logic [2:0] {
      halted,
      fetch,
      execute,
      memAccess,
      writeRes
   } state_e;

   typedef enum logic [3:0] {
      add,
      sub,
      xorOp,
      orOp,
      andOp,
      sll,
      srl,
      sra,
      slt,
      sltu,
      passB   // operand b straight through
   } aluOp_e;

endpackage

// ==== rtl/execUnit.sv ====
module execUnit (
   input  corePkg::aluOp_e          aluOp,
   input  logic                     useImm,
   input  logic [isaPkg::xlen-1:0]  rs1Data,
   input  logic [isaPkg::xlen-1:0]  rs2Data,
   input  logic [isaPkg::xlen-1:0]  imm,
   output logic [isaPkg::xlen-1:0]  aluOut
);

   logic [isaPkg::xlen-1:0] opA;
   logic [isaPkg::xlen-1:0] opB;
   logic [4:0]              shamt;
   logic                    ltSigned;
   logic                    ltUnsigned;

   assign opA   = rs1Data;
   assign opB   = useImm ? imm : rs2Data;
   assign shamt = opB[4:0];   // low bits only, also for register shifts

   assign ltSigned   = $signed(opA) < $signed(opB);
   assign ltUnsigned = opA < opB;   // sltiu sees the sign-extended imm as unsigned

   // loads and stores come through here as add, giving the word address
   always_comb begin
      case (aluOp)
         corePkg::add:   aluOut = opA + opB;
         corePkg::sub:   aluOut = opA - opB;
         corePkg::xorOp: aluOut = opA ^ opB;
         corePkg::orOp:  aluOut = opA | opB;
         corePkg::andOp: aluOut = opA & opB;
         corePkg::sll:   aluOut = opA << shamt;
         corePkg::srl:   aluOut = opA >> shamt;
         corePkg::sra:   aluOut = $unsigned($signed(opA) >>> shamt);
         corePkg::slt:   aluOut = {{(isaPkg::xlen-1){1'b0}}, ltSigned};
         corePkg::sltu:  aluOut = {{(isaPkg::xlen-1){1'b0}}, ltUnsigned};
         corePkg::passB: aluOut = opB;
         default:        aluOut = '0;
      endcase
   end

endmodule

// ==== rtl/instrDecode.sv ====
module instrDecode (
   input  logic [isaPkg::xlen-1:0]      instr,
   output logic [isaPkg::regAddrW-1:0]  rs1,
   output logic [isaPkg::regAddrW-1:0]  rs2,
   output logic [isaPkg::regAddrW-1:0]  rd,
   output logic [isaPkg::xlen-1:0]      imm,
   output corePkg::aluOp_e              aluOp,
   output logic                         useImm,
   output logic                         isLui,
   output logic                         isLoad,
   output logic                         isStore,
   output logic                         isHalt,
   output logic                         writesRd,
   output logic                         invalid
);

   isaPkg::opcode_e              opc;
   logic [isaPkg::funct3W-1:0]   funct3;
   logic [isaPkg::funct7W-1:0]   funct7;
   logic [isaPkg::xlen-1:0]      immI;
   logic [isaPkg::xlen-1:0]      immS;
   logic [isaPkg::xlen-1:0]      shamt;

   assign opc    = isaPkg::opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rd     = instr[11:7];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];

   assign immI  = {{20{instr[31]}}, instr[31:20]};
   assign immS  = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // split store field
   assign shamt = {27'b0, instr[24:20]};

   always_comb begin
      imm      = immI;
      aluOp    = corePkg::passB;
      useImm   = 1'b0;
      isLui    = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      isHalt   = 1'b0;
      writesRd = 1'b0;
      invalid  = 1'b0;
      case (opc)
         isaPkg::opImm: begin
            useImm   = 1'b1;
            writesRd = 1'b1;
            case (funct3)
               isaPkg::f3Add:  aluOp = corePkg::add;
               isaPkg::f3Slt:  aluOp = corePkg::slt;
               isaPkg::f3Sltu: aluOp = corePkg::sltu;
               isaPkg::f3Xor:  aluOp = corePkg::xorOp;
               isaPkg::f3Or:   aluOp = corePkg::orOp;
               isaPkg::f3And:  aluOp = corePkg::andOp;
               isaPkg::f3Sll: begin
                  aluOp = corePkg::sll;
                  imm   = shamt;
               end
               isaPkg::f3Srl: begin
                  imm = shamt;
                  if (funct7 == isaPkg::funct7Base) begin
                     aluOp = corePkg::srl;
                  end else if (funct7 == isaPkg::funct7Alt) begin
                     aluOp = corePkg::sra;
                  end else begin
                     invalid = 1'b1;
                  end
               end
               default: invalid = 1'b1;
            endcase
         end
         isaPkg::lui: begin
            isLui    = 1'b1;
            useImm   = 1'b1;
            writesRd = 1'b1;
            imm      = {12'b0, instr[31:12]};   // shifted up in writeBack
         end
         isaPkg::op: begin
            writesRd = 1'b1;
            if (funct7 == isaPkg::funct7Base) begin
               case (funct3)
                  isaPkg::f3Add: aluOp = corePkg::add;
                  isaPkg::f3Xor: aluOp = corePkg::xorOp;
                  isaPkg::f3Or:  aluOp = corePkg::orOp;
                  isaPkg::f3And: aluOp = corePkg::andOp;
                  isaPkg::f3Sll: aluOp = corePkg::sll;
                  default:       invalid = 1'b1;
               endcase
            end else if (funct7 == isaPkg::funct7Alt && funct3 == isaPkg::f3Add) begin
               aluOp = corePkg::sub;
            end else begin
               invalid = 1'b1;
            end
         end
         isaPkg::load: begin
            isLoad   = 1'b1;
            useImm   = 1'b1;
            writesRd = 1'b1;
            aluOp    = corePkg::add;
            invalid  = (funct3 != isaPkg::f3Lw);   // lw only
         end
         isaPkg::store: begin
            isStore = 1'b1;
            useImm  = 1'b1;
            imm     = immS;
            aluOp   = corePkg::add;
         end
         isaPkg::halt: isHalt = 1'b1;
         default: invalid = 1'b1;
      endcase
      if (invalid) begin
         writesRd = 1'b0;
      end
   end

endmodule

// ==== rtl/isaPkg.sv ====
package isaPkg;

   localparam int xlen     = 32;
   localparam int regAddrW = 5;
   localparam int opcodeW  = 7;
   localparam int funct3W  = 3;
   localparam int funct7W  = 7;

   // major opcodes of the supported subset
   typedef enum logic [opcodeW-1:0] {
      opImm = 7'b0010011,
      lui   = 7'b0110111,
      op    = 7'b0110011,
      load  = 7'b0000011,
      store = 7'b0100011,
      halt  = 7'b1111111   // all ones stops the core
   } opcode_e;

   localparam logic [funct3W-1:0] f3Add  = 3'b000;  // also sub
   localparam logic [funct3W-1:0] f3Sll  = 3'b001;
   localparam logic [funct3W-1:0] f3Slt  = 3'b010;
   localparam logic [funct3W-1:0] f3Sltu = 3'b011;
   localparam logic [funct3W-1:0] f3Xor  = 3'b100;
   localparam logic [funct3W-1:0] f3Srl  = 3'b101;  // also sra
   localparam logic [funct3W-1:0] f3Or   = 3'b110;
   localparam logic [funct3W-1:0] f3And  = 3'b111;

   // word load/store
   localparam logic [funct3W-1:0] f3Lw   = 3'b010;
   localparam logic [funct3W-1:0] f3Sw   = 3'b010;

   localparam logic [funct7W-1:0] funct7Base = 7'b0000000;
   localparam logic [funct7W-1:0] funct7Alt  = 7'b0100000;  // sub, sra

endpackage

// ==== rtl/lanzonesCore.sv ====
module lanzonesCore (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     loadEn,
   input  logic                     busAck,
   input  logic [isaPkg::xlen-1:0]  busRData,
   output logic                     busReq,
   output logic [isaPkg::xlen-1:0]  busAddr,
   output logic                     busWe,
   output logic [isaPkg::xlen-1:0]  busWData,
   output logic                     halt
);

   logic [isaPkg::xlen-1:0]      instr;
   corePkg::state_e              state;
   logic [isaPkg::regAddrW-1:0]  rs1;
   logic [isaPkg::regAddrW-1:0]  rs2;
   logic [isaPkg::regAddrW-1:0]  rd;
   logic [isaPkg::xlen-1:0]      imm;
   corePkg::aluOp_e              aluOp;
   logic                         useImm;
   logic                         isLui;
   logic                         isLoad;
   logic                         isStore;
   logic                         isHalt;
   logic                         writesRd;
   logic                         invalid;
   logic [isaPkg::xlen-1:0]      aluOut;
   logic [isaPkg::xlen-1:0]      rs1Data;
   logic [isaPkg::xlen-1:0]      rs2Data;
   logic                         we;
   logic [isaPkg::regAddrW-1:0]  wAddr;
   logic [isaPkg::xlen-1:0]      wData;

   busSequencer seq_i (
      .clk, .rstn, .loadEn, .busAck, .busRData, .isStore, .isLoad, .isHalt, .invalid,
      .aluOut, .rs2Data, .busReq, .busAddr, .busWe, .busWData, .instr, .state, .halt
   );

   instrDecode dec_i (
      .instr, .rs1, .rs2, .rd, .imm, .aluOp, .useImm, .isLui, .isLoad, .isStore,
      .isHalt, .writesRd, .invalid
   );

   execUnit exe_i (
      .aluOp, .useImm, .rs1Data, .rs2Data, .imm, .aluOut
   );

   regFile rf_i (
      .clk, .rstn, .rs1, .rs2, .we, .wAddr, .wData, .rs1Data, .rs2Data
   );

   writeBack wb_i (
      .clk, .rstn, .state, .isLui, .isLoad, .writesRd, .rd, .imm, .aluOut, .busAck,
      .busRData, .we, .wAddr, .wData
   );

endmodule

// ==== rtl/regFile.sv ====
module regFile (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic [isaPkg::regAddrW-1:0]  rs1,
   input  logic [isaPkg::regAddrW-1:0]  rs2,
   input  logic                         we,
   input  logic [isaPkg::regAddrW-1:0]  wAddr,
   input  logic [isaPkg::xlen-1:0]      wData,
   output logic [isaPkg::xlen-1:0]      rs1Data,
   output logic [isaPkg::xlen-1:0]      rs2Data
);

   logic [isaPkg::xlen-1:0] regs [2**isaPkg::regAddrW];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 2**isaPkg::regAddrW; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wAddr != '0) begin   // x0 stays zero
         regs[wAddr] <= wData;
      end
   end

   assign rs1Data = regs[rs1];
   assign rs2Data = regs[rs2];

endmodule

// ==== rtl/writeBack.sv ====
module writeBack (
   input  logic                         clk,
   input  logic                         rstn,
   input  corePkg::state_e              state,
   input  logic                         isLui,
   input  logic                         isLoad,
   input  logic                         writesRd,
   input  logic [isaPkg::regAddrW-1:0]  rd,
   input  logic [isaPkg::xlen-1:0]      imm,
   input  logic [isaPkg::xlen-1:0]      aluOut,
   input  logic                         busAck,
   input  logic [isaPkg::xlen-1:0]      busRData,
   output logic                         we,
   output logic [isaPkg::regAddrW-1:0]  wAddr,
   output logic [isaPkg::xlen-1:0]      wData
);

   logic loadDone;

   assign loadDone = state == corePkg::memAccess && isLoad && busAck;

   // high only for the writeRes cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         we <= 1'b0;
      end else begin
         we <= (state == corePkg::execute && writesRd && !isLoad) || loadDone;
      end
   end

   always_ff @(posedge clk) begin
      if (state == corePkg::execute) begin
         wAddr <= rd;
         if (isLui) begin
            wData <= {imm[19:0], 12'b0};
         end else begin
            wData <= aluOut;
         end
      end else if (loadDone) begin
         wData <= busRData;   // taken on the ack edge
      end
   end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# build and run the lanzonesCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert --top-module lanzonesTb -Mdir "$buildDir" -f lanzonesCore.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$buildDir/VlanzonesTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -q "ERRORS FOUND" "$logFile"; then
   exit 1
fi
exit 0

// ==== sim/lanzonesTb.sv ====
module lanzonesTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int memWords  = 1024;
   localparam int progLen   = 200;
   localparam int dumpLen   = 31;
   localparam int dataBase  = 512;
   localparam int dumpBaseA = 768;
   localparam int dumpBaseB = 800;
   // each instruction stays under 12 cycles with the longest ack wait
   localparam int cycleLimit = (progLen + 2 * dumpLen + 3) * 12 + 800;
   localparam logic [31:0] seed = 32'h3583_50f7;

   logic                    clk      = 1'b0;
   logic                    rstn     = 1'b0;
   logic                    loadEn   = 1'b0;
   logic                    busAck   = 1'b0;
   logic [isaPkg::xlen-1:0] busRData = '0;
   logic                    busReq;
   logic [isaPkg::xlen-1:0] busAddr;
   logic                    busWe;
   logic [isaPkg::xlen-1:0] busWData;
   logic                    halt;

   logic [31:0] mem [memWords];
   logic [31:0] modelMem [memWords];
   logic [31:0] modelRegs [32];
   logic [31:0] modelPc;
   logic        expWe [$];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   int          phaseEnd [3];
   int          cycles = 0;
   int          doneCount = 0;
   int          mismatches = 0;
   int          otherErrs = 0;
   bit          waiting = 1'b0;
   int          waitLeft = 0;
   bit          holding = 1'b0;
   logic [31:0] heldAddr;
   logic        heldWe;
   logic [31:0] heldWData;

   lanzonesCore dut_i (
      .clk, .rstn, .loadEn, .busAck, .busRData, .busReq, .busAddr, .busWe, .busWData, .halt
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] randInstr();
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      logic [11:0] memOff;
      int          kind;
      rd     = 5'($urandom);
      rs1    = 5'($urandom);
      rs2    = 5'($urandom);
      imm    = 12'($urandom);
      memOff = 12'(dataBase + int'($urandom % 256));   // data region, based on x0
      kind   = int'($urandom % 18);
      case (kind)
         0:  return iType(imm, rs1, 3'b000, rd, 7'h13);
         1:  return iType(imm, rs1, 3'b010, rd, 7'h13);
         2:  return iType(imm, rs1, 3'b011, rd, 7'h13);
         3:  return iType(imm, rs1, 3'b100, rd, 7'h13);
         4:  return iType(imm, rs1, 3'b110, rd, 7'h13);
         5:  return iType(imm, rs1, 3'b111, rd, 7'h13);
         6:  return iType({7'h00, rs2}, rs1, 3'b001, rd, 7'h13);   // shamt in rs2 field
         7:  return iType({7'h00, rs2}, rs1, 3'b101, rd, 7'h13);
         8:  return iType({7'h20, rs2}, rs1, 3'b101, rd, 7'h13);
         9:  return {20'($urandom), rd, 7'h37};
         10: return rType(7'h00, rs2, rs1, 3'b000, rd);
         11: return rType(7'h20, rs2, rs1, 3'b000, rd);
         12: return rType(7'h00, rs2, rs1, 3'b100, rd);
         13: return rType(7'h00, rs2, rs1, 3'b110, rd);
         14: return rType(7'h00, rs2, rs1, 3'b111, rd);
         15: return rType(7'h00, rs2, rs1, 3'b001, rd);
         16: return iType(memOff, 5'd0, 3'b010, rd, 7'h03);
         default: return sType(memOff, rs2, 5'd0);
      endcase
   endfunction

   task automatic addDump(inout int idx, input int base);
      for (int r = 1; r <= dumpLen; r++) begin
         mem[10'(idx)] = sType(12'(base + r), 5'(r), 5'd0);
         idx++;
      end
   endtask

   task automatic buildProgram();
      int idx;
      idx = 0;
      for (int i = 0; i < memWords; i++) begin
         mem[10'(i)] = (32'(i) * 32'h9E37_79B9) ^ 32'hC0DE_0000;
      end
      for (int i = 0; i < progLen; i++) begin
         mem[10'(idx)] = randInstr();
         idx++;
      end
      addDump(idx, dumpBaseA);
      mem[10'(idx)] = 32'hFFFF_FFFF;
      mem[10'(idx + 1)] = iType({7'b0100001, 5'd3}, 5'd6, 3'b101, 5'd5, 7'h13);   // bad srai
      idx = idx + 2;
      addDump(idx, dumpBaseB);
      mem[10'(idx)] = 32'hFFFF_FFFF;
   endtask

   task automatic expectTransfer(logic we, logic [31:0] addr, logic [31:0] data);
      expWe.push_back(we);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   // ISA model, runs until a halt or an invalid word
   task automatic runModel();
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] immI;
      logic [31:0] immS;
      logic [31:0] res;
      logic [4:0]  sh;
      logic        wr;
      logic        stop;
      stop = 1'b0;
      while (!stop) begin
         w = modelMem[modelPc[9:0]];
         expectTransfer(1'b0, modelPc, '0);
         modelPc = modelPc + 1;
         a    = modelRegs[w[19:15]];
         b    = modelRegs[w[24:20]];
         immI = {{20{w[31]}}, w[31:20]};
         immS = {{20{w[31]}}, w[31:25], w[11:7]};
         sh   = w[24:20];
         res  = '0;
         wr   = 1'b1;
         case (w[6:0])
            7'h13: begin
               case (w[14:12])
                  3'b000: res = a + immI;
                  3'b010: res = ($signed(a) < $signed(immI)) ? 32'd1 : 32'd0;
                  3'b011: res = (a < immI) ? 32'd1 : 32'd0;
                  3'b100: res = a ^ immI;
                  3'b110: res = a | immI;
                  3'b111: res = a & immI;
                  3'b001: res = a << sh;
                  default: begin
                     if (w[31:25] == 7'h00) begin
                        res = a >> sh;
                     end else if (w[31:25] == 7'h20) begin
                        res = $signed(a) >>> sh;
                     end else begin
                        wr   = 1'b0;
                        stop = 1'b1;
                     end
                  end
               endcase
            end
            7'h37: res = {w[31:12], 12'b0};
            7'h33: begin
               case (w[14:12])
                  3'b000: res = (w[31:25] == 7'h20) ? a - b : a + b;
                  3'b001: res = a << b[4:0];
                  3'b100: res = a ^ b;
                  3'b110: res = a | b;
                  default: res = a & b;
               endcase
            end
            7'h03: begin
               expectTransfer(1'b0, a + immI, '0);
               res = modelMem[10'(a + immI)];
            end
            7'h23: begin
               expectTransfer(1'b1, a + immS, b);
               modelMem[10'(a + immS)] = b;
               wr = 1'b0;
            end
            default: begin   // halt opcode or anything unknown
               wr   = 1'b0;
               stop = 1'b1;
            end
         endcase
         if (wr && w[11:7] != 5'd0) begin
            modelRegs[w[11:7]] = res;
         end
      end
   endtask

   task automatic checkTransfer();
      logic        eWe;
      logic [31:0] eAddr;
      logic [31:0] eData;
      if (expAddr.size() == 0) begin
         otherErrs++;
         $display("bus transfer at %h with no transfer left in the model", busAddr);
      end else begin
         eWe   = expWe.pop_front();
         eAddr = expAddr.pop_front();
         eData = expData.pop_front();
         if (busWe !== eWe) begin
            mismatches++;
            $display("Mismatch busWe: got %h expected %h", busWe, eWe);
         end
         if (busAddr !== eAddr) begin
            mismatches++;
            $display("Mismatch busAddr: got %h expected %h", busAddr, eAddr);
         end
         if (eWe && busWData !== eData) begin
            mismatches++;
            $display("Mismatch busWData: got %h expected %h", busWData, eData);
         end
      end
      doneCount++;
      if (busAddr < 32'(memWords)) begin
         if (busWe) begin
            mem[busAddr[9:0]] = busWData;
         end else begin
            busRData = mem[busAddr[9:0]];
         end
      end else begin
         otherErrs++;
         $display("bus address %h lies outside the memory", busAddr);
      end
   endtask

   // memory model and bus monitor
   always @(negedge clk) begin
      if (!rstn) begin
         busAck  = 1'b0;
         waiting = 1'b0;
         holding = 1'b0;
      end else begin
         if (halt && busReq) begin
            otherErrs++;
            $display("bus request raised while the core is halted");
         end
         if (holding && !busReq) begin
            otherErrs++;
            $display("bus request dropped before its acknowledge");
         end
         if (holding && busReq && busAddr !== heldAddr) begin
            mismatches++;
            $display("Mismatch busAddr: got %h expected %h", busAddr, heldAddr);
         end
         if (holding && busReq && busWe !== heldWe) begin
            mismatches++;
            $display("Mismatch busWe: got %h expected %h", busWe, heldWe);
         end
         if (holding && busReq && busWData !== heldWData) begin
            mismatches++;
            $display("Mismatch busWData: got %h expected %h", busWData, heldWData);
         end
         if (busAck) begin
            busAck = 1'b0;   // transfer ended on the last rising edge
            if (busReq) begin
               otherErrs++;
               $display("bus request still high after its acknowledge");
            end
         end else if (busReq) begin
            if (!waiting) begin
               waiting  = 1'b1;
               waitLeft = int'($urandom % 4);
            end
            if (waitLeft == 0) begin
               waiting = 1'b0;
               checkTransfer();
               busAck = 1'b1;
            end else begin
               waitLeft--;
            end
         end
         holding   = busReq && !busAck;
         heldAddr  = busAddr;
         heldWe    = busWe;
         heldWData = busWData;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("timeout after %0d cycles, %0d transfers still expected", cycles,
                  expAddr.size());
         $display("mismatches %0d, other errors %0d", mismatches, otherErrs + 1);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      void'($urandom(seed));
      buildProgram();
      for (int i = 0; i < memWords; i++) begin
         modelMem[10'(i)] = mem[10'(i)];
      end
      for (int i = 0; i < 32; i++) begin
         modelRegs[5'(i)] = '0;
      end
      modelPc = '0;
      for (int p = 0; p < 3; p++) begin
         runModel();
         phaseEnd[p] = expAddr.size();
      end

      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      repeat (3) begin
         @(negedge clk);
         if (halt !== 1'b1 || busReq !== 1'b0 || busWe !== 1'b0) begin
            otherErrs++;
            $display("core is not halted and idle after reset");
         end
      end

      // program, then the bad srai alone, then the second dump
      for (int p = 0; p < 3; p++) begin
         @(negedge clk);
         loadEn = 1'b1;
         @(negedge clk);
         loadEn = 1'b0;
         if (halt) begin
            otherErrs++;
            $display("core stayed halted after loadEn in phase %0d", p);
         end
         while (!halt) @(negedge clk);
         if (doneCount != phaseEnd[p]) begin
            otherErrs++;
            $display("phase %0d halted after %0d transfers instead of %0d", p, doneCount,
                     phaseEnd[p]);
         end
         repeat (6) @(negedge clk);   // quiet bus while halted
      end
      if (expAddr.size() != 0) begin
         otherErrs++;
         $display("%0d expected transfers never happened", expAddr.size());
      end

      $display("mismatches %0d, other errors %0d", mismatches, otherErrs);
      if (mismatches + otherErrs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
